/* hdl/ifetch_config.svh */
`ifndef IFETCH_CONFIG_SVH
`define IFETCH_CONFIG_SVH

//////////////////////////////////////////////////
// Fetch unit configuration
//////////////////////////////////////////////////

// Granted requests allowed to wait for a response
`define IFETCH_MAX_OUTSTANDING 2

// Start of the region that needs response integrity checks
`define IFETCH_INTEGRITY_BASE 32'h8000_0000

// Instruction word width
`define IFETCH_DATA_W 32

// Word count width of a fetch command
`define IFETCH_LEN_W 8

`endif

/* hdl/ifetch_pkg.sv */
`default_nettype none

`include "ifetch_config.svh"

package ifetch_pkg;

  // Plain vector types
  typedef logic [31:0]                  addr_t;
  typedef logic [`IFETCH_DATA_W-1:0]    word_t;
  typedef logic [5:0]                   achk_t;
  typedef logic [4:0]                   rchk_t;
  typedef logic [`IFETCH_LEN_W-1:0]     len_t;

  // Request from the address generator to the adapter
  typedef struct packed {
    addr_t       addr;
    logic [2:0]  prot;
    logic        dbg;
    logic        integrity;
  } fetch_req_t;

  // OBI A channel, master side
  typedef struct packed {
    logic        req;
    logic        reqpar;
    addr_t       addr;
    logic [2:0]  prot;
    logic        dbg;
    achk_t       achk;
  } obi_req_t;

  // OBI grant with its parity
  typedef struct packed {
    logic        gnt;
    logic        gntpar;
  } obi_gnt_t;

  // OBI R channel
  typedef struct packed {
    logic        rvalid;
    logic        rvalidpar;
    word_t       rdata;
    logic        err;
    rchk_t       rchk;
  } obi_resp_t;

  // Response from the adapter, with integrity results appended
  typedef struct packed {
    word_t       rdata;
    logic        err;
    logic        integrity;
    logic        integrity_err;
  } fetch_resp_t;

  // Fetched word leaving the unit
  typedef struct packed {
    addr_t       addr;
    word_t       rdata;
    logic        bus_err;
    logic        integrity_err;
  } instr_t;

  typedef enum logic {TRANSPARENT, REGISTERED} obi_state_e;
  typedef enum logic {IDLE, FETCH} gen_state_e;

endpackage

`default_nettype wire

/* hdl/ifetch_rchk_check.sv */
`timescale 1ns/1ps
`default_nettype none

module ifetch_rchk_check (
  input  wire ifetch_pkg::obi_resp_t resp_i,
  input  wire logic                  enable_i,
  output logic                       err_o
);
  import ifetch_pkg::*;

  rchk_t       rchk_exp;       // Recomputed checksum
  logic [3:0]  data_mismatch;  // One bit per rdata byte
  logic        err_mismatch;

  //////////////////////////////////////////////////
  // Expected checksum
  //////////////////////////////////////////////////

  // Even parity of each rdata byte
  always_comb begin
    rchk_exp[0] = ^resp_i.rdata[7:0];
    rchk_exp[1] = ^resp_i.rdata[15:8];
    rchk_exp[2] = ^resp_i.rdata[23:16];
    rchk_exp[3] = ^resp_i.rdata[31:24];
    // Even parity of the error bit
    rchk_exp[4] = ^resp_i.err;
  end

  //////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////

  // Data and err fields compared on their own
  assign data_mismatch = rchk_exp[3:0] ^ resp_i.rchk[3:0];
  assign err_mismatch  = rchk_exp[4] ^ resp_i.rchk[4];

  // Reported only while the check is enabled
  assign err_o = enable_i && ((|data_mismatch) || err_mismatch);

endmodule

`default_nettype wire

/* hdl/ifetch_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_config.svh"

module ifetch_addr_gen (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  start_i,
  input  wire ifetch_pkg::addr_t     start_addr_i,
  input  wire ifetch_pkg::len_t      len_i,
  output logic                       trans_valid_o,
  input  wire logic                  trans_ready_i,
  output ifetch_pkg::fetch_req_t     trans_o,
  input  wire logic                  resp_valid_i,
  input  wire ifetch_pkg::fetch_resp_t resp_i,
  output logic                       instr_valid_o,
  output ifetch_pkg::instr_t         instr_o,
  output logic                       busy_o
);
  import ifetch_pkg::*;

  localparam int    MAX_OUT  = `IFETCH_MAX_OUTSTANDING;
  localparam int    OUT_W    = $clog2(MAX_OUT + 1);
  localparam addr_t INT_BASE = `IFETCH_INTEGRITY_BASE;

  gen_state_e        state_q;
  addr_t             req_addr_q;   // Next address to issue
  addr_t             rsp_addr_q;   // Address of the next response
  len_t              len_q;
  len_t              issued_q;
  len_t              rcvd_q;
  len_t              rcvd_next;
  logic [OUT_W-1:0]  outst_q;      // Taken by the adapter, not yet answered
  logic              issue;
  logic              start;

  // Start only from idle, so start_i is ignored while busy
  assign start = (state_q == IDLE) && start_i;

  // Issue while words remain and the outstanding limit allows
  assign trans_valid_o = (state_q == FETCH) && (issued_q != len_q)
                         && (outst_q < OUT_W'(MAX_OUT));
  assign issue         = trans_valid_o && trans_ready_i;
  assign rcvd_next     = rcvd_q + len_t'(resp_valid_i);

  // Fixed attributes for instruction fetches
  assign trans_o.addr      = req_addr_q;
  assign trans_o.prot      = 3'b100;
  assign trans_o.dbg       = 1'b0;
  assign trans_o.integrity = (req_addr_q >= INT_BASE);

  //////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      issued_q <= '0;
      rcvd_q   <= '0;
      outst_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start) begin
            state_q  <= FETCH;
            issued_q <= '0;
            rcvd_q   <= '0;
            outst_q  <= '0;
          end
        end
        FETCH: begin
          issued_q <= issued_q + len_t'(issue);
          rcvd_q   <= rcvd_next;
          // Up on a taken request, down on a response
          case ({issue, resp_valid_i})
            2'b10:   outst_q <= outst_q + 1'b1;
            2'b01:   outst_q <= outst_q - 1'b1;
            default: outst_q <= outst_q;
          endcase
          // Last response seen, busy drops next cycle
          if (rcvd_next == len_q) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Addresses and length
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (start) begin
      // Fetches are word aligned
      req_addr_q <= {start_addr_i[31:2], 2'b00};
      rsp_addr_q <= {start_addr_i[31:2], 2'b00};
      len_q      <= len_i;
    end else begin
      if (issue) begin
        req_addr_q <= req_addr_q + 32'd4;
      end
      if (resp_valid_i) begin
        rsp_addr_q <= rsp_addr_q + 32'd4;
      end
    end
  end

  // Returned word tagged with its address
  assign instr_valid_o         = resp_valid_i;
  assign instr_o.addr          = rsp_addr_q;
  assign instr_o.rdata         = resp_i.rdata;
  assign instr_o.bus_err       = resp_i.err;
  assign instr_o.integrity_err = resp_i.integrity_err;

  assign busy_o = (state_q == FETCH);

endmodule

`default_nettype wire

/* hdl/ifetch_obi_adapter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_config.svh"

module ifetch_obi_adapter (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    trans_valid_i,
  output logic                         trans_ready_o,
  input  wire ifetch_pkg::fetch_req_t  trans_i,
  output logic                         resp_valid_o,
  output ifetch_pkg::fetch_resp_t      resp_o,
  input  wire logic                    integrity_en_i,
  output logic                         integrity_err_o,
  output ifetch_pkg::obi_req_t         obi_req_o,
  input  wire ifetch_pkg::obi_gnt_t    obi_gnt_i,
  input  wire ifetch_pkg::obi_resp_t   obi_resp_i
);
  import ifetch_pkg::*;

  localparam int MAX_OUT = `IFETCH_MAX_OUTSTANDING;
  localparam int CNT_W   = $clog2(MAX_OUT + 1);

  // Per transaction record kept until its response
  typedef struct packed {
    logic integrity;
    logic gnterr;
  } gnt_fifo_t;

  obi_state_e               state_q;
  obi_state_e               next_state;
  fetch_req_t               a_req_q;     // Latched A channel while not granted
  fetch_req_t               a_cur;       // A channel fields as driven
  logic                     a_req;
  achk_t                    achk;

  // Entry 0 stays low so cnt_q indexes the oldest entry directly
  gnt_fifo_t [MAX_OUT:0]    fifo_q;
  gnt_fifo_t                fifo_in;
  gnt_fifo_t                fifo_out;

  logic [CNT_W-1:0]         cnt_q;
  logic                     count_up;
  logic                     count_down;

  logic                     gntpar_err;      // Immediate
  logic                     gntpar_err_q;    // Sticky over a waited grant
  logic                     rvalidpar_err;
  logic                     rchk_en;
  logic                     rchk_err;

  //////////////////////////////////////////////////
  // A channel state machine
  //////////////////////////////////////////////////

  always_comb begin
    next_state = state_q;
    case (state_q)
      // Request not granted at once, hold the address phase
      TRANSPARENT: if (a_req && !obi_gnt_i.gnt) next_state = REGISTERED;
      // Back to pass-through on grant
      REGISTERED:  if (obi_gnt_i.gnt) next_state = TRANSPARENT;
      default:     next_state = TRANSPARENT;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= TRANSPARENT;
    end else begin
      state_q <= next_state;
    end
  end

  // Capture the request that goes unanswered
  always_ff @(posedge clk) begin
    if ((state_q == TRANSPARENT) && (next_state == REGISTERED)) begin
      a_req_q <= trans_i;
    end
  end

  // Pass-through or held values
  assign a_cur         = (state_q == TRANSPARENT) ? trans_i : a_req_q;
  // Request is never withdrawn while waiting
  assign a_req         = (state_q == TRANSPARENT) ? trans_valid_i : 1'b1;
  assign trans_ready_o = (state_q == TRANSPARENT);

  //////////////////////////////////////////////////
  // A channel integrity
  //////////////////////////////////////////////////

  // Odd parity per address byte, prot and dbg
  always_comb begin
    achk[0] = ~^a_cur.addr[7:0];
    achk[1] = ~^a_cur.addr[15:8];
    achk[2] = ~^a_cur.addr[23:16];
    achk[3] = ~^a_cur.addr[31:24];
    achk[4] = ~^a_cur.prot;
    achk[5] = ~^a_cur.dbg;
  end

  always_comb begin
    obi_req_o.req    = a_req;
    obi_req_o.reqpar = ~a_req;
    obi_req_o.addr   = a_cur.addr;
    obi_req_o.prot   = a_cur.prot;
    obi_req_o.dbg    = a_cur.dbg;
    obi_req_o.achk   = achk;
  end

  //////////////////////////////////////////////////
  // Outstanding count and grant error FIFO
  //////////////////////////////////////////////////

  assign count_up   = a_req && obi_gnt_i.gnt;
  assign count_down = obi_resp_i.rvalid;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      case ({count_up, count_down})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Parity flags mismatch when both bits are equal
  assign gntpar_err    = (obi_gnt_i.gnt == obi_gnt_i.gntpar);
  assign rvalidpar_err = (obi_resp_i.rvalid == obi_resp_i.rvalidpar);

  // Remember a grant parity error seen while waiting, clear on accept
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      gntpar_err_q <= 1'b0;
    end else if (a_req) begin
      gntpar_err_q <= obi_gnt_i.gnt ? 1'b0 : (gntpar_err_q || gntpar_err);
    end
  end

  assign fifo_in.integrity = a_cur.integrity;
  assign fifo_in.gnterr    = gntpar_err || gntpar_err_q;

  // Newest enters at 1, older entries move up by one
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      fifo_q <= '0;
    end else if (count_up) begin
      fifo_q <= {fifo_q[MAX_OUT-1:1], fifo_in, gnt_fifo_t'('0)};
    end
  end

  assign fifo_out = fifo_q[cnt_q];

  //////////////////////////////////////////////////
  // R channel
  //////////////////////////////////////////////////

  // Checksum only inside the integrity region and when enabled
  assign rchk_en = obi_resp_i.rvalid && fifo_out.integrity && integrity_en_i;

  ifetch_rchk_check rchk_check_i (
    .resp_i   (obi_resp_i),
    .enable_i (rchk_en),
    .err_o    (rchk_err)
  );

  // Consumer is always ready
  assign resp_valid_o         = obi_resp_i.rvalid;
  assign resp_o.rdata         = obi_resp_i.rdata;
  assign resp_o.err           = obi_resp_i.err;
  assign resp_o.integrity     = fifo_out.integrity;
  assign resp_o.integrity_err = rvalidpar_err || fifo_out.gnterr || rchk_err;

  // Immediate flag, any time
  assign integrity_err_o = gntpar_err || rvalidpar_err || rchk_err;

endmodule

`default_nettype wire

/* hdl/ifetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ifetch_top (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  start_i,
  input  wire ifetch_pkg::addr_t     start_addr_i,
  input  wire ifetch_pkg::len_t      len_i,
  input  wire logic                  integrity_en_i,
  output logic                       instr_valid_o,
  output ifetch_pkg::instr_t         instr_o,
  output logic                       busy_o,
  output logic                       integrity_err_o,
  output ifetch_pkg::obi_req_t       obi_req_o,
  input  wire ifetch_pkg::obi_gnt_t  obi_gnt_i,
  input  wire ifetch_pkg::obi_resp_t obi_resp_i
);
  import ifetch_pkg::*;

  // Generator to adapter
  logic         trans_valid;
  logic         trans_ready;
  fetch_req_t   trans;

  // Adapter to generator
  logic         resp_valid;
  fetch_resp_t  resp;

  ifetch_addr_gen addr_gen_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .start_addr_i  (start_addr_i),
    .len_i         (len_i),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_o       (trans),
    .resp_valid_i  (resp_valid),
    .resp_i        (resp),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .busy_o        (busy_o)
  );

  ifetch_obi_adapter obi_adapter_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .trans_valid_i   (trans_valid),
    .trans_ready_o   (trans_ready),
    .trans_i         (trans),
    .resp_valid_o    (resp_valid),
    .resp_o          (resp),
    .integrity_en_i  (integrity_en_i),
    .integrity_err_o (integrity_err_o),
    .obi_req_o       (obi_req_o),
    .obi_gnt_i       (obi_gnt_i),
    .obi_resp_i      (obi_resp_i)
  );

endmodule

`default_nettype wire

/* testbench/ifetch_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_config.svh"

module ifetch_checker #(
  parameter int CNT_W = $clog2(`IFETCH_MAX_OUTSTANDING + 1)
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire ifetch_pkg::obi_req_t  obi_req_i,
  input  wire ifetch_pkg::obi_gnt_t  obi_gnt_i,
  input  wire ifetch_pkg::obi_resp_t obi_resp_i,
  input  wire logic [CNT_W-1:0]      outst_i
);
  import ifetch_pkg::*;

  logic [41:0]  a_chan;          // addr, prot, dbg, achk
  int unsigned  fail_count = 0;

  assign a_chan = {obi_req_i.addr, obi_req_i.prot, obi_req_i.dbg, obi_req_i.achk};

  //////////////////////////////////////////////////
  // OBI A and R channel rules
  //////////////////////////////////////////////////

  // Ungranted request stays up with a frozen address phase
  req_held_a: assert property (@(posedge clk) disable iff (!rst_n)
      (obi_req_i.req && !obi_gnt_i.gnt) |=> (obi_req_i.req && $stable(a_chan)))
    else begin
      fail_count++;
      $error("A channel changed or req dropped before gnt");
    end

  // Request parity
  reqpar_a: assert property (@(posedge clk) disable iff (!rst_n)
      obi_req_i.reqpar == ~obi_req_i.req)
    else begin
      fail_count++;
      $error("reqpar is not the inverse of req");
    end

  // A response needs a granted request behind it
  rvalid_outst_a: assert property (@(posedge clk) disable iff (!rst_n)
      obi_resp_i.rvalid |-> (outst_i != '0))
    else begin
      fail_count++;
      $error("rvalid with no request outstanding");
    end

endmodule

bind ifetch_obi_adapter ifetch_checker protocol_checker_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .obi_req_i  (obi_req_o),
  .obi_gnt_i  (obi_gnt_i),
  .obi_resp_i (obi_resp_i),
  .outst_i    (cnt_q)
);

`default_nettype wire

/* testbench/ifetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ifetch_tb;
  import ifetch_pkg::*;

  localparam int    FIELDS    = 13;
  localparam int    MAX_TESTS = 32;
  localparam word_t PATTERN   = 32'hA5A5_5A5A;

  // DUT ports
  logic        clk;
  logic        rst_n;
  logic        start_i;
  addr_t       start_addr_i;
  len_t        len_i;
  logic        integrity_en_i;
  logic        instr_valid_o;
  instr_t      instr_o;
  logic        busy_o;
  logic        integrity_err_o;
  obi_req_t    obi_req_o;
  obi_gnt_t    obi_gnt_i;
  obi_resp_t   obi_resp_i;

  // Test table, FIELDS values per test
  logic [31:0] tests [0:FIELDS*MAX_TESTS-1];
  int          num_tests;

  // Current test, shared with the slave model and the monitor
  addr_t       t_addr;
  int          t_len;
  int          t_gnt_dly;
  int          t_rsp_dly;
  int          inj_idx [4];    // gntpar, rvalidpar, rchk, err
  logic        exp_flag [4];

  // Slave model state
  int          seed;
  int          cycle;
  int          limit;
  logic        limit_set;
  int          wait_cnt;
  int          wait_target;
  int          grant_idx;
  int          resp_idx;
  addr_t       rsp_addr_q [$];
  int          rsp_due_q [$];

  // Scoreboard
  int          rx_count;
  int          acc_count;      // Accepted requests of the current test
  logic        saw_int_err;
  int          checks;
  int          errors;

  ifetch_top ifetch_top_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start_i),
    .start_addr_i    (start_addr_i),
    .len_i           (len_i),
    .integrity_en_i  (integrity_en_i),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .busy_o          (busy_o),
    .integrity_err_o (integrity_err_o),
    .obi_req_o       (obi_req_o),
    .obi_gnt_i       (obi_gnt_i),
    .obi_resp_i      (obi_resp_i)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Cycle count, doubles as the run limit
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (limit_set && (cycle >= limit)) begin
      $display("timeout after %0d cycles, fetch never finished", cycle);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_field(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      $display("ERROR %0t %s expected %h got %h", $time, name, exp_val, act_val);
      errors++;
    end
  endtask

  // Even parity per rdata byte, then of err
  function automatic rchk_t resp_checksum(input word_t data, input logic err);
    rchk_t c;
    c[0] = ^data[7:0];
    c[1] = ^data[15:8];
    c[2] = ^data[23:16];
    c[3] = ^data[31:24];
    c[4] = err;
    return c;
  endfunction

  // Odd parity per address byte and of prot, dbg inverted
  function automatic achk_t addr_checksum(input addr_t addr, input logic [2:0] prot,
                                          input logic dbg);
    achk_t c;
    for (int b = 0; b < 4; b++) begin
      c[b] = ~^addr[8*b +: 8];
    end
    c[4] = ~^prot;
    c[5] = ~dbg;
    return c;
  endfunction

  // Base grant delay plus a random stall when delays are on
  function automatic int grant_wait();
    int extra;
    extra = 0;
    if (t_gnt_dly != 0) begin
      extra = {$random(seed)} % 3;
    end
    return t_gnt_dly + extra;
  endfunction

  function automatic logic expected_integrity(input int n);
    logic e;
    e = 1'b0;
    for (int k = 0; k < 4; k++) begin
      if ((n == inj_idx[k]) && exp_flag[k]) e = 1'b1;
    end
    return e;
  endfunction

  //////////////////////////////////////////////////
  // OBI slave model
  //////////////////////////////////////////////////

  always @(posedge clk) begin : obi_slave
    logic  gnt;
    logic  flip;
    addr_t addr;
    logic  err;
    #1;
    if (!rst_n) begin
      obi_gnt_i.gnt        = 1'b0;
      obi_gnt_i.gntpar     = 1'b1;
      obi_resp_i.rvalid    = 1'b0;
      obi_resp_i.rvalidpar = 1'b1;
      rsp_addr_q.delete();
      rsp_due_q.delete();
      wait_cnt = 0;
    end else begin
      gnt  = 1'b0;
      flip = 1'b0;
      // Grant once the request has waited long enough
      if (obi_req_o.req) begin
        if (wait_cnt >= wait_target) begin
          gnt  = 1'b1;
          flip = (grant_idx == inj_idx[0]);
          rsp_addr_q.push_back(obi_req_o.addr);
          rsp_due_q.push_back(cycle + 1 + t_rsp_dly);
          grant_idx++;
          wait_cnt    = 0;
          wait_target = grant_wait();
        end else begin
          wait_cnt++;
        end
      end
      obi_gnt_i.gnt    = gnt;
      obi_gnt_i.gntpar = ~gnt ^ flip;
      // In-order responses, one per cycle at most
      obi_resp_i.rvalid    = 1'b0;
      obi_resp_i.rvalidpar = 1'b1;
      obi_resp_i.rdata     = '0;
      obi_resp_i.err       = 1'b0;
      obi_resp_i.rchk      = '0;
      if ((rsp_due_q.size() != 0) && (rsp_due_q[0] <= cycle)) begin
        addr = rsp_addr_q.pop_front();
        void'(rsp_due_q.pop_front());
        err  = (resp_idx == inj_idx[3]);
        obi_resp_i.rvalid    = 1'b1;
        obi_resp_i.rvalidpar = (resp_idx == inj_idx[1]);
        obi_resp_i.rdata     = addr ^ PATTERN;
        obi_resp_i.err       = err;
        obi_resp_i.rchk      = resp_checksum(addr ^ PATTERN, err);
        if (resp_idx == inj_idx[2]) begin
          obi_resp_i.rchk[0] = ~obi_resp_i.rchk[0];
        end
        resp_idx++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Output monitor, mid cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin : monitor
    addr_t exp_addr;
    addr_t exp_req;
    if (rst_n) begin
      if (integrity_err_o) saw_int_err = 1'b1;
      // Accepted A channel request, sequential and with fetch attributes
      if (obi_req_o.req && obi_gnt_i.gnt) begin
        exp_req = t_addr + 32'(4 * acc_count);
        check_field("obi_req_o.addr", exp_req, obi_req_o.addr);
        check_field("obi_req_o.prot", 32'(3'b100), 32'(obi_req_o.prot));
        check_field("obi_req_o.dbg", 0, 32'(obi_req_o.dbg));
        check_field("obi_req_o.achk", 32'(addr_checksum(exp_req, 3'b100, 1'b0)),
                    32'(obi_req_o.achk));
        acc_count++;
      end
      if (instr_valid_o) begin
        if (rx_count >= t_len) begin
          $display("ERROR %0t word returned beyond the fetch length of %0d", $time, t_len);
          errors++;
        end else begin
          exp_addr = t_addr + 32'(4 * rx_count);
          check_field("instr_o.addr", exp_addr, instr_o.addr);
          check_field("instr_o.rdata", exp_addr ^ PATTERN, instr_o.rdata);
          check_field("instr_o.bus_err", 32'(rx_count == inj_idx[3]), 32'(instr_o.bus_err));
          check_field("instr_o.integrity_err", 32'(expected_integrity(rx_count)),
                      32'(instr_o.integrity_err));
        end
        rx_count++;
      end
    end
  end

  task automatic check_idle();
    check_field("obi_req_o.req", 0, obi_req_o.req);
    check_field("instr_valid_o", 0, instr_valid_o);
    check_field("busy_o", 0, busy_o);
    check_field("integrity_err_o", 0, integrity_err_o);
  endtask

  task automatic run_test(input int t);
    int   base;
    logic exp_pulse;
    base = t * FIELDS;
    @(posedge clk);
    #1;
    t_addr    = tests[base];
    t_len     = tests[base+1];
    t_gnt_dly = tests[base+3];
    t_rsp_dly = tests[base+4];
    for (int k = 0; k < 4; k++) begin
      inj_idx[k]  = tests[base+5+k];
      exp_flag[k] = tests[base+9+k][0];
    end
    grant_idx   = 0;
    resp_idx    = 0;
    wait_cnt    = 0;
    wait_target = grant_wait();
    rx_count    = 0;
    acc_count   = 0;
    saw_int_err = 1'b0;
    check_field("busy_o", 0, busy_o);
    start_i        = 1'b1;
    start_addr_i   = t_addr;
    len_i          = len_t'(t_len);
    integrity_en_i = tests[base+2][0];
    // Second start while busy, must be ignored
    @(posedge clk);
    #1;
    check_field("busy_o", 1, busy_o);
    start_addr_i = 32'h0BAD_0000;
    len_i        = len_t'(3);
    @(posedge clk);
    #1;
    start_i = 1'b0;
    // Fetch ends when busy drops
    @(negedge clk);
    while (busy_o) @(negedge clk);
    check_field("word count", t_len, rx_count);
    exp_pulse = 1'b0;
    for (int k = 0; k < 4; k++) begin
      if ((inj_idx[k] < t_len) && exp_flag[k]) exp_pulse = 1'b1;
    end
    check_field("integrity_err_o pulse", 32'(exp_pulse), 32'(saw_int_err));
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    seed      = 26;
    cycle     = 0;
    limit     = 200;
    limit_set = 1'b0;
    checks    = 0;
    errors    = 0;
    t_len     = 0;
    t_addr    = '0;
    rx_count  = 0;
    acc_count = 0;
    for (int k = 0; k < 4; k++) begin
      inj_idx[k]  = 'hFF;
      exp_flag[k] = 1'b0;
    end
    rst_n                = 1'b0;
    start_i              = 1'b0;
    start_addr_i         = '0;
    len_i                = '0;
    integrity_en_i       = 1'b0;
    obi_gnt_i.gnt        = 1'b0;
    obi_gnt_i.gntpar     = 1'b1;
    obi_resp_i           = '0;
    obi_resp_i.rvalidpar = 1'b1;
    $readmemh("testbench/ifetch_tests.txt", tests);
    num_tests = 0;
    while ((num_tests < MAX_TESTS) && !$isunknown(tests[num_tests*FIELDS])) num_tests++;
    for (int t = 0; t < num_tests; t++) begin
      limit += tests[t*FIELDS+1] * (tests[t*FIELDS+3] + tests[t*FIELDS+4] + 8);
    end
    limit_set = 1'b1;
    if (num_tests == 0) begin
      $display("no tests found in testbench/ifetch_tests.txt");
      errors++;
    end
    // Reset held for 5 cycles
    repeat (4) begin
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_idle();
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    errors += ifetch_top_i.obi_adapter_i.protocol_checker_i.fail_count;
    $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/ifetch_tests.txt */
// addr len integrity_en gnt_dly rsp_dly | injected word index: gntpar rvalidpar rchk err (FF none)
// then the expected integrity_err flag of the gntpar, rvalidpar, rchk and err words
00001000 08 0 0 0 FF FF FF FF 0 0 0 0
00001100 01 0 0 0 FF FF FF FF 0 0 0 0
00002000 10 0 0 2 FF FF FF FF 0 0 0 0
00003000 0C 0 2 1 FF FF FF FF 0 0 0 0
00004000 10 1 3 3 FF FF FF FF 0 0 0 0
00005000 08 0 1 0 03 FF FF FF 1 0 0 0
00006000 06 0 0 2 00 FF FF FF 1 0 0 0
00007000 08 0 0 1 FF 02 FF FF 0 1 0 0
00008000 08 0 2 0 FF FF FF 05 0 0 0 0
80000000 08 1 0 1 FF FF 04 FF 0 0 1 0
80000100 08 0 0 1 FF FF 04 FF 0 0 0 0
00009000 08 1 0 1 FF FF 04 FF 0 0 0 0
7FFFFFF8 04 1 1 1 FF FF 01 FF 0 0 0 0
7FFFFFF8 04 1 1 1 FF FF 02 FF 0 0 1 0
8000A000 0A 1 2 2 01 04 07 08 1 1 1 0
8000B000 06 1 0 0 FF FF FF 02 0 0 0 0

/* ifetch.f */
+incdir+hdl
hdl/ifetch_pkg.sv
hdl/ifetch_rchk_check.sv
hdl/ifetch_addr_gen.sv
hdl/ifetch_obi_adapter.sv
hdl/ifetch_top.sv
testbench/ifetch_checker.sv
testbench/ifetch_tb.sv

/* Bender.yml */
package:
  name: ifetch

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ifetch_pkg.sv
      - hdl/ifetch_rchk_check.sv
      - hdl/ifetch_addr_gen.sv
      - hdl/ifetch_obi_adapter.sv
      - hdl/ifetch_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/ifetch_checker.sv
      - testbench/ifetch_tb.sv
